/* src/ahb_defs.svh */
`ifndef AHB_DEFS_SVH
`define AHB_DEFS_SVH

// HTRANS codes
`define TRN_IDLE   2'b00
`define TRN_NONSEQ 2'b10

`define SIZ_32BIT  3'b010 // HSIZE for one word
`define BUR_SINGLE 3'b000 // HBURST for a single transfer

// HRESP codes
`define RSP_OKAY   2'b00
`define RSP_ERROR  2'b01

`define MEM_WORDS  256 // words in the SRAM slave
`define SLAVE_WAIT 2   // wait states in every data phase

`endif

/* src/ahbPkg.sv */
package ahbPkg;

	// request from a client into a master wrapper
	typedef struct packed {
		logic        write;
		logic [31:0] addr; // word address
		logic [31:0] wdata;
	} clientReqT;

	// response back to the client
	typedef struct packed {
		logic [31:0] rdata;
		logic        err; // set when the slave answered ERROR
	} clientRspT;

	// address-phase control that a master puts on the bus
	typedef struct packed {
		logic [1:0]  trans;
		logic        write;
		logic [2:0]  size;
		logic [2:0]  burst;
		logic [31:0] addr;
	} ahbAddrT;

	// slave response, shared by both masters
	typedef struct packed {
		logic        ready;
		logic [1:0]  resp;
		logic [31:0] rdata;
	} ahbRspT;

endpackage

/* src/ahbMasterIo.sv */
`timescale 1ns/10ps
`include "ahb_defs.svh"

module ahbMasterIo (
	input  logic              HCLK,
	input  logic              arstN,
	input  ahbPkg::clientReqT req,
	input  logic              reqValid,
	output logic              reqReady,
	output ahbPkg::clientRspT rsp,
	output logic              rspValid,
	input  logic              rspReady,
	output logic              busReq,
	input  logic              hgrant,
	output ahbPkg::ahbAddrT   addrPh,
	output logic [31:0]       hwdata,
	input  ahbPkg::ahbRspT    busRsp
);
	import ahbPkg::*;

	typedef enum logic [2:0] {
		IDLE,
		REQ,
		ADDR,
		DATA,
		RSP
	} stateT;

	stateT     state;
	stateT     nextState;
	clientReqT reqQ; // request held for the whole transfer
	clientRspT rspQ;

	assign reqReady = (state == IDLE);
	assign rspValid = (state == RSP);
	assign busReq = (state == REQ) || (state == ADDR) || (state == DATA);
	assign rsp = rspQ;

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (reqValid) begin
					nextState = REQ;
				end
			end
			REQ: begin
				if (hgrant && busRsp.ready) begin // bus is ours and free
					nextState = ADDR;
				end
			end
			ADDR: begin
				if (busRsp.ready) begin
					nextState = DATA;
				end
			end
			DATA: begin
				if (busRsp.ready) begin
					nextState = RSP;
				end
			end
			RSP: begin
				if (rspReady) begin
					nextState = IDLE;
				end
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	always_ff @(posedge HCLK or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge HCLK) begin
		if (state == IDLE && reqValid) begin
			reqQ <= req;
		end
		if (state == DATA && busRsp.ready) begin // end of data phase
			rspQ.rdata <= reqQ.write ? 32'd0 : busRsp.rdata;
			rspQ.err <= (busRsp.resp == `RSP_ERROR);
		end
	end

	always_comb begin
		addrPh.trans = (state == ADDR) ? `TRN_NONSEQ : `TRN_IDLE;
		addrPh.write = reqQ.write;
		addrPh.size = `SIZ_32BIT;
		addrPh.burst = `BUR_SINGLE;
		addrPh.addr = reqQ.addr;
	end

	// write data only while our data phase runs
	assign hwdata = (state == DATA && reqQ.write) ? reqQ.wdata : 32'd0;

endmodule

/* src/ahbInterconnect.sv */
`timescale 1ns/10ps
`include "ahb_defs.svh"

module ahbInterconnect (
	input  logic            HCLK,
	input  logic            arstN,
	input  logic [1:0]      busReq,
	output logic [1:0]      hgrant,
	input  ahbPkg::ahbAddrT addrPh0,
	input  ahbPkg::ahbAddrT addrPh1,
	input  logic [31:0]     hwdata0,
	input  logic [31:0]     hwdata1,
	input  ahbPkg::ahbRspT  busRsp,
	output ahbPkg::ahbAddrT haddrPh,
	output logic [31:0]     hwdata
);
	logic grantValid;
	logic addrOwner; // master that owns the address bus
	logic dataOwner; // master whose data phase is running
	logic dataActive;
	logic rrPtr; // master tried first at the next decision
	logic reDecide;
	logic pick;
	logic addrDone;

	// the owner keeps busReq high until its data phase has ended
	assign reDecide = !dataActive && !(grantValid && busReq[addrOwner]);
	assign pick = busReq[rrPtr] ? rrPtr : !rrPtr;
	assign addrDone = (haddrPh.trans == `TRN_NONSEQ) && busRsp.ready;

	always_ff @(posedge HCLK or negedge arstN) begin
		if (!arstN) begin
			grantValid <= 1'b0;
			addrOwner <= 1'b0;
			rrPtr <= 1'b0;
			dataActive <= 1'b0;
			dataOwner <= 1'b0;
		end else begin
			if (reDecide) begin
				grantValid <= |busReq;
				if (|busReq) begin
					addrOwner <= pick;
					rrPtr <= !pick; // the other master goes first next time
				end
			end
			if (addrDone) begin
				dataActive <= 1'b1;
				dataOwner <= addrOwner;
			end else if (dataActive && busRsp.ready) begin
				dataActive <= 1'b0;
			end
		end
	end

	assign hgrant = grantValid ? (addrOwner ? 2'b10 : 2'b01) : 2'b00;

	always_comb begin
		haddrPh = addrOwner ? addrPh1 : addrPh0;
		if (!grantValid) begin
			haddrPh.trans = `TRN_IDLE;
		end
	end

	assign hwdata = dataOwner ? hwdata1 : hwdata0;

endmodule

/* src/ahbSramSlave.sv */
`timescale 1ns/10ps
`include "ahb_defs.svh"

module ahbSramSlave (
	input  logic            HCLK,
	input  logic            arstN,
	input  ahbPkg::ahbAddrT haddrPh,
	input  logic [31:0]     hwdata,
	output ahbPkg::ahbRspT  busRsp
);
	localparam int AW = $clog2(`MEM_WORDS);

	logic [31:0]   mem [`MEM_WORDS];
	logic          active; // a data phase is in progress
	logic          writeQ;
	logic [31:0]   addrQ;
	logic [3:0]    waitCnt;
	logic          lastCycle;
	logic          acceptAddr;
	logic          inRange;
	logic [AW-1:0] idx;

	assign lastCycle = active && (waitCnt == 4'(`SLAVE_WAIT));
	assign acceptAddr = (!active || lastCycle) && (haddrPh.trans == `TRN_NONSEQ);
	assign inRange = (addrQ < 32'(`MEM_WORDS));
	assign idx = addrQ[AW-1:0];

	always_ff @(posedge HCLK or negedge arstN) begin
		if (!arstN) begin
			active <= 1'b0;
			waitCnt <= 4'd0;
		end else if (!active || lastCycle) begin
			active <= acceptAddr;
			waitCnt <= 4'd0;
		end else begin
			waitCnt <= waitCnt + 4'd1;
		end
	end

	always_ff @(posedge HCLK) begin
		if (acceptAddr) begin
			addrQ <= haddrPh.addr;
			writeQ <= haddrPh.write;
		end
		if (lastCycle && writeQ && inRange) begin // write lands on the final edge
			mem[idx] <= hwdata;
		end
	end

	always_comb begin
		busRsp.ready = !active || lastCycle;
		// ERROR is held through the wait states, so it spans at least two cycles
		busRsp.resp = (active && !inRange) ? `RSP_ERROR : `RSP_OKAY;
		busRsp.rdata = (lastCycle && !writeQ && inRange) ? mem[idx] : 32'd0;
	end

endmodule

/* src/ahbSys.sv */
`timescale 1ns/10ps

module ahbSys (
	input  logic              HCLK,
	input  logic              arstN,
	input  ahbPkg::clientReqT req0,
	input  logic              req0Valid,
	output logic              req0Ready,
	output ahbPkg::clientRspT rsp0,
	output logic              rsp0Valid,
	input  logic              rsp0Ready,
	input  ahbPkg::clientReqT req1,
	input  logic              req1Valid,
	output logic              req1Ready,
	output ahbPkg::clientRspT rsp1,
	output logic              rsp1Valid,
	input  logic              rsp1Ready
);
	import ahbPkg::*;

	logic [1:0]  busReq;
	logic [1:0]  hgrant;
	ahbAddrT     addrPh0;
	ahbAddrT     addrPh1;
	logic [31:0] hwdata0;
	logic [31:0] hwdata1;
	ahbAddrT     haddrPh; // address phase as the slave sees it
	logic [31:0] hwdata;
	ahbRspT      busRsp;

	ahbMasterIo i_master0 (
		.HCLK(HCLK), .arstN(arstN),
		.req(req0), .reqValid(req0Valid), .reqReady(req0Ready),
		.rsp(rsp0), .rspValid(rsp0Valid), .rspReady(rsp0Ready),
		.busReq(busReq[0]), .hgrant(hgrant[0]),
		.addrPh(addrPh0), .hwdata(hwdata0), .busRsp(busRsp)
	);

	ahbMasterIo i_master1 (
		.HCLK(HCLK), .arstN(arstN),
		.req(req1), .reqValid(req1Valid), .reqReady(req1Ready),
		.rsp(rsp1), .rspValid(rsp1Valid), .rspReady(rsp1Ready),
		.busReq(busReq[1]), .hgrant(hgrant[1]),
		.addrPh(addrPh1), .hwdata(hwdata1), .busRsp(busRsp)
	);

	ahbInterconnect i_interconnect (
		.HCLK(HCLK), .arstN(arstN),
		.busReq(busReq), .hgrant(hgrant),
		.addrPh0(addrPh0), .addrPh1(addrPh1),
		.hwdata0(hwdata0), .hwdata1(hwdata1),
		.busRsp(busRsp), .haddrPh(haddrPh), .hwdata(hwdata)
	);

	ahbSramSlave i_sram (
		.HCLK(HCLK), .arstN(arstN),
		.haddrPh(haddrPh), .hwdata(hwdata), .busRsp(busRsp)
	);

endmodule

/* testbench/ahbSys_props.sv */
`timescale 1ns/10ps
`include "ahb_defs.svh"

module ahbSysProps (
	input logic            HCLK,
	input logic            arstN,
	input logic [1:0]      hgrant,
	input logic            dataActive,
	input ahbPkg::ahbAddrT addrPh0,
	input ahbPkg::ahbAddrT addrPh1
);
	import ahbPkg::*;

	// only one master may drive an address phase at a time
	oneAddrOwner: assert property (@(posedge HCLK) disable iff (!arstN)
		$onehot0({addrPh1.trans == `TRN_NONSEQ, addrPh0.trans == `TRN_NONSEQ}))
		else $error("both masters issued NONSEQ in the same cycle");

	grantHeld: assert property (@(posedge HCLK) disable iff (!arstN)
		dataActive |=> $stable(hgrant))
		else $error("grant changed during a data phase");

	// a master starts a transfer only with the grant in hand
	nonseq0Granted: assert property (@(posedge HCLK) disable iff (!arstN)
		(addrPh0.trans == `TRN_NONSEQ) |-> hgrant[0])
		else $error("master 0 issued NONSEQ without the grant");

	nonseq1Granted: assert property (@(posedge HCLK) disable iff (!arstN)
		(addrPh1.trans == `TRN_NONSEQ) |-> hgrant[1])
		else $error("master 1 issued NONSEQ without the grant");

endmodule

bind ahbInterconnect ahbSysProps i_props (
	.HCLK(HCLK),
	.arstN(arstN),
	.hgrant(hgrant),
	.dataActive(dataActive),
	.addrPh0(addrPh0),
	.addrPh1(addrPh1)
);

/* testbench/ahbSysTb.sv */
`timescale 1ns/10ps
`include "ahb_defs.svh"

module ahbSysTb;
	import ahbPkg::*;

	localparam int TOTAL_TXNS = 455;
	localparam real TIMEOUT_NS = TOTAL_TXNS * 40 * 40.0;

	logic      HCLK;
	logic      arstN;
	clientReqT reqD [2];
	logic      reqValidD [2];
	logic      reqReadyO [2];
	clientRspT rspO [2];
	logic      rspValidO [2];
	logic      rspReadyD [2];

	logic [31:0] model [`MEM_WORDS]; // reference memory, written in grant order
	bit          known [`MEM_WORDS];
	clientReqT   curReq [2]; // request each client has in flight
	clientRspT   expQ0 [$];
	clientRspT   expQ1 [$];
	bit          knownQ0 [$];
	bit          knownQ1 [$];
	bit          pendingAcc [2];
	int          skipCnt [2];
	bit          prevHeld [2];
	clientRspT   prevRsp [2];
	int          issued [2];
	int          doneCnt [2];
	int          stallPct [2];
	int          errCount;
	int          checkCount;
	int          testCount;
	int          testStartErr;
	string       curTest;

	ahbSys i_ahbSys (
		.HCLK(HCLK), .arstN(arstN),
		.req0(reqD[0]), .req0Valid(reqValidD[0]), .req0Ready(reqReadyO[0]),
		.rsp0(rspO[0]), .rsp0Valid(rspValidO[0]), .rsp0Ready(rspReadyD[0]),
		.req1(reqD[1]), .req1Valid(reqValidD[1]), .req1Ready(reqReadyO[1]),
		.rsp1(rspO[1]), .rsp1Valid(rspValidO[1]), .rsp1Ready(rspReadyD[1])
	);

	initial begin
		HCLK = 1'b0;
		forever #20 HCLK = ~HCLK;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish in %0.0f ns", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic checkFlag(input string what, input logic expV, input logic actV);
		checkCount++;
		if (actV !== expV) begin
			errCount++;
			$display("mismatch %s %s: expected %0b actual %0b", curTest, what, expV, actV);
		end
	endtask

	// rdata is compared only when the model knows the word
	task automatic checkRsp(input string what, input clientRspT expV, input clientRspT actV,
			input bit dataKnown);
		checkCount++;
		if (actV.err !== expV.err || (dataKnown && actV.rdata !== expV.rdata)) begin
			errCount++;
			$display("mismatch %s %s: expected rdata %h err %0b actual rdata %h err %0b",
				curTest, what, expV.rdata, expV.err, actV.rdata, actV.err);
		end
	endtask

	// the model acts when an address phase completes on the coming edge
	task automatic modelAddrPhase(input int m);
		clientReqT r;
		clientRspT e;
		bit        k;
		bit        inR;
		int        o;
		r = curReq[m];
		inR = (r.addr < `MEM_WORDS);
		k = 1'b1;
		e.err = !inR;
		e.rdata = 32'd0;
		if (r.write && inR) begin
			model[r.addr[7:0]] = r.wdata;
			known[r.addr[7:0]] = 1'b1;
		end else if (!r.write && inR) begin
			e.rdata = model[r.addr[7:0]];
			k = known[r.addr[7:0]];
		end
		if (m == 0) begin
			expQ0.push_back(e);
			knownQ0.push_back(k);
		end else begin
			expQ1.push_back(e);
			knownQ1.push_back(k);
		end
		o = 1 - m;
		pendingAcc[m] = 1'b0;
		skipCnt[m] = 0;
		if (pendingAcc[o]) begin
			skipCnt[o]++;
			checkFlag($sformatf("client %0d waits at most two grants", o), 1'b1, skipCnt[o] <= 2);
		end
	endtask

	task automatic takeRsp(input int c);
		clientRspT e;
		bit        k;
		if ((c == 0 && expQ0.size() == 0) || (c == 1 && expQ1.size() == 0)) begin
			errCount++;
			$display("client %0d got a response with no request pending in %s", c, curTest);
		end else begin
			e = (c == 0) ? expQ0.pop_front() : expQ1.pop_front();
			k = (c == 0) ? knownQ0.pop_front() : knownQ1.pop_front();
			checkRsp($sformatf("client %0d response", c), e, rspO[c], k);
		end
		doneCnt[c]++;
	endtask

	always @(negedge HCLK) begin
		if (arstN) begin
			if (i_ahbSys.haddrPh.trans == `TRN_NONSEQ && i_ahbSys.busRsp.ready) begin
				modelAddrPhase(i_ahbSys.hgrant[1] ? 1 : 0);
			end
			for (int c = 0; c < 2; c++) begin
				if (prevHeld[c]) begin // response must hold while stalled
					checkFlag($sformatf("client %0d rspValid held", c), 1'b1, rspValidO[c]);
					checkRsp($sformatf("client %0d rsp held", c), prevRsp[c], rspO[c], 1'b1);
					checkFlag($sformatf("client %0d reqReady low", c), 1'b0, reqReadyO[c]);
				end
				prevHeld[c] = rspValidO[c] && !rspReadyD[c];
				prevRsp[c] = rspO[c];
				if (reqValidD[c] && reqReadyO[c]) begin
					curReq[c] = reqD[c];
					pendingAcc[c] = 1'b1;
				end
				if (rspValidO[c] && rspReadyD[c]) begin
					takeRsp(c);
				end
			end
		end
	end

	always @(posedge HCLK) begin
		#2;
		for (int c = 0; c < 2; c++) begin
			rspReadyD[c] = ($urandom_range(99) >= stallPct[c]);
		end
	end

	task automatic sendReq(input int c, input logic wr, input logic [31:0] addr,
			input logic [31:0] wd);
		@(posedge HCLK);
		#2;
		reqD[c].write = wr;
		reqD[c].addr = addr;
		reqD[c].wdata = wd;
		reqValidD[c] = 1'b1;
		@(negedge HCLK);
		while (!reqReadyO[c]) @(negedge HCLK);
		issued[c]++;
		@(posedge HCLK);
		#2;
		reqValidD[c] = 1'b0;
	endtask

	task automatic runClient(input int c, input int n, input int addrMax, input int gapMax);
		for (int i = 0; i < n; i++) begin
			repeat ($urandom_range(gapMax)) @(posedge HCLK);
			sendReq(c, 1'($urandom_range(1)), $urandom_range(addrMax), $urandom);
		end
	endtask

	task automatic waitDone();
		while (doneCnt[0] != issued[0] || doneCnt[1] != issued[1]) @(posedge HCLK);
		repeat (4) @(posedge HCLK); // a stray extra response would show up here
		checkFlag("no extra response", 1'b1, doneCnt[0] == issued[0] && doneCnt[1] == issued[1]);
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testStartErr = errCount;
	endtask

	task automatic finishTest();
		testCount++;
		$display("test %s: %0d errors", curTest, errCount - testStartErr);
	endtask

	initial begin
		void'($urandom(48));
		arstN = 1'b0;
		for (int c = 0; c < 2; c++) begin
			reqD[c] = '0;
			reqValidD[c] = 1'b0;
			rspReadyD[c] = 1'b1;
			stallPct[c] = 0;
		end
		repeat (16) @(posedge HCLK);
		#2;
		arstN = 1'b1;

		startTest("reset");
		@(negedge HCLK);
		for (int c = 0; c < 2; c++) begin
			checkFlag($sformatf("client %0d reqReady", c), 1'b1, reqReadyO[c]);
			checkFlag($sformatf("client %0d rspValid", c), 1'b0, rspValidO[c]);
		end
		finishTest();

		startTest("writeRead");
		sendReq(0, 1'b1, 32'd17, 32'hCAFE_0017);
		sendReq(0, 1'b0, 32'd17, 32'd0);
		waitDone();
		finishTest();

		startTest("outOfRange");
		sendReq(1, 1'b1, 32'd273, 32'hDEAD_BEEF); // aliases word 17 if the range check fails
		sendReq(1, 1'b0, 32'd273, 32'd0);
		sendReq(1, 1'b0, 32'd17, 32'd0);
		waitDone();
		finishTest();

		startTest("twoClients");
		fork
			runClient(0, 20, 31, 0);
			runClient(1, 20, 31, 0);
		join
		waitDone();
		finishTest();

		startTest("backPressure");
		stallPct[0] = 90;
		runClient(0, 10, 63, 1);
		waitDone();
		stallPct[0] = 0;
		finishTest();

		startTest("randomMix");
		stallPct[0] = 30;
		stallPct[1] = 30;
		fork
			runClient(0, 200, 287, 3);
			runClient(1, 200, 287, 3);
		join
		waitDone();
		finishTest();

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* ahbSys.f */
+incdir+src
src/ahbPkg.sv
src/ahbMasterIo.sv
src/ahbInterconnect.sv
src/ahbSramSlave.sv
src/ahbSys.sv
testbench/ahbSys_props.sv
testbench/ahbSysTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ahbSys testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ahbSysTb \
	-f ahbSys.f -o ahbSysSim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/ahbSysSim > sim.log 2>&1 && echo "simulation finished" || echo "simulation exited with error"

grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
